// ==== hw/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////////////////////////
	// shared types
	////////////////////////////////////////////////////////////

	// one instruction or one byte address
	typedef logic [31:0] word_t;

	// addi x0, x0, 0
	localparam word_t NOP_INSTR = 32'h0000_0013;

	////////////////////////////////////////////////////////////
	// state machines
	////////////////////////////////////////////////////////////

	// serial receiver
	typedef enum logic [2:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop,
		rx_handoff
	} rx_state_e;

	// memory programmer
	typedef enum logic [1:0] {
		prog_idle,
		prog_collect,
		prog_write,
		prog_wait_release
	} prog_state_e;

	// next address source in fetch
	typedef enum logic [1:0] {
		pc_seq,
		pc_rel,
		pc_abs
	} pc_sel_e;

endpackage

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import fetch_pkg::*; #(
	parameter int IMEM_AW = 8
) (
	input  logic               bus,
	input  logic               arst_n,
	input  logic               pc_en,
	input  logic               prog_busy,
	input  logic               branch,
	input  logic               jal,
	input  logic               jalr,
	input  word_t              branch_off,
	input  word_t              rd_data,
	output logic               rd_en,
	output logic [IMEM_AW-1:0] rd_addr,
	output word_t              instr,
	output word_t              instr_pc,
	output logic               instr_valid
);

	word_t   pc_q;
	word_t   next_pc;
	pc_sel_e pc_sel;
	logic    fetch_go;
	logic    redirect;
	logic    valid_q;

	// no fetch while memory is being loaded
	assign fetch_go = pc_en && !prog_busy;

	assign rd_en   = fetch_go;
	// drop the byte offset
	assign rd_addr = pc_q[IMEM_AW+1:2];

	////////////////////////////////////////////////////////////
	// next address
	////////////////////////////////////////////////////////////

	// control only counts against a valid output
	// jalr wins over branch and jal
	always_comb begin
		pc_sel = pc_seq;
		if (valid_q) begin
			if (jalr) begin
				pc_sel = pc_abs;
			end else if (branch || jal) begin
				pc_sel = pc_rel;
			end
		end
	end

	always_comb begin
		case (pc_sel)
			pc_abs:  next_pc = branch_off;
			pc_rel:  next_pc = instr_pc + branch_off;
			default: next_pc = pc_q + 32'd4;
		endcase
	end

	// a taken redirect loads the pc even in a stall cycle
	assign redirect = (pc_sel != pc_seq);

	////////////////////////////////////////////////////////////
	// pc and output registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge bus or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= '0;
		end else if (prog_busy) begin
			// restart from zero once programming ends
			pc_q <= '0;
		end else if (fetch_go || redirect) begin
			pc_q <= next_pc;
		end
	end

	// address and valid flag of the read in flight
	always_ff @(posedge bus or negedge arst_n) begin
		if (!arst_n) begin
			valid_q  <= 1'b0;
			instr_pc <= '0;
		end else begin
			valid_q <= fetch_go;
			if (fetch_go) begin
				instr_pc <= pc_q;
			end
		end
	end

	// nop whenever nothing valid is out
	assign instr       = valid_q ? rd_data : NOP_INSTR;
	assign instr_valid = valid_q;

	// jalr target taken as is, whatever branch or jal say
	a_jalr_prio: assert property (@(posedge bus) disable iff (!arst_n)
		(instr_valid && jalr && !prog_busy) |=> (pc_q == $past(branch_off)));

	// offsets from decode keep the pc on word boundaries
	a_pc_aligned: assert property (@(posedge bus) disable iff (!arst_n)
		pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_top import fetch_pkg::*; #(
	parameter int CLKS_PER_BIT = 16,
	parameter int IMEM_AW      = 8
) (
	input  logic  bus,
	input  logic  arst_n,
	input  logic  rx,
	input  logic  prog,
	input  logic  pc_en,
	input  logic  branch,
	input  logic  jal,
	input  logic  jalr,
	input  word_t branch_off,
	output word_t instr,
	output word_t instr_pc,
	output logic  instr_valid,
	output logic  prog_busy
);

	////////////////////////////////////////////////////////////
	// interconnect
	////////////////////////////////////////////////////////////

	// serial byte handshake
	logic               byte_req;
	logic               byte_ack;
	logic [7:0]         byte_data;
	// programmer write port
	logic               wr_en;
	logic [IMEM_AW-1:0] wr_addr;
	word_t              wr_data;
	// fetch read port
	logic               rd_en;
	logic [IMEM_AW-1:0] rd_addr;
	word_t              rd_data;

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_uart_rx (
		.bus       (bus),
		.arst_n    (arst_n),
		.rx        (rx),
		.byte_ack  (byte_ack),
		.byte_req  (byte_req),
		.byte_data (byte_data)
	);

	imem_programmer #(
		.IMEM_AW(IMEM_AW)
	) u_imem_programmer (
		.bus       (bus),
		.arst_n    (arst_n),
		.prog      (prog),
		.byte_req  (byte_req),
		.byte_data (byte_data),
		.byte_ack  (byte_ack),
		.prog_busy (prog_busy),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	instr_mem #(
		.IMEM_AW(IMEM_AW)
	) u_instr_mem (
		.bus     (bus),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_data (rd_data)
	);

	fetch_stage #(
		.IMEM_AW(IMEM_AW)
	) u_fetch_stage (
		.bus         (bus),
		.arst_n      (arst_n),
		.pc_en       (pc_en),
		.prog_busy   (prog_busy),
		.branch      (branch),
		.jal         (jal),
		.jalr        (jalr),
		.branch_off  (branch_off),
		.rd_data     (rd_data),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.instr_valid (instr_valid)
	);

endmodule

`default_nettype wire

// ==== hw/imem_programmer.sv ====
`timescale 1ns/1ns
`default_nettype none

module imem_programmer import fetch_pkg::*; #(
	parameter int IMEM_AW = 8
) (
	input  logic               bus,
	input  logic               arst_n,
	input  logic               prog,
	input  logic               byte_req,
	input  logic [7:0]         byte_data,
	output logic               byte_ack,
	output logic               prog_busy,
	output logic               wr_en,
	output logic [IMEM_AW-1:0] wr_addr,
	output word_t              wr_data
);

	prog_state_e        state;
	logic [1:0]         byte_cnt;
	logic [IMEM_AW-1:0] word_addr;
	word_t              word_q;
	logic               byte_take;

	// new byte offered and not yet acked
	assign byte_take = byte_req && !byte_ack;

	////////////////////////////////////////////////////////////
	// byte handshake
	////////////////////////////////////////////////////////////

	// every byte is acked so the receiver never hangs
	// outside of programming the byte is simply dropped
	always_ff @(posedge bus or negedge arst_n) begin
		if (!arst_n) begin
			byte_ack <= 1'b0;
		end else if (byte_take) begin
			byte_ack <= 1'b1;
		end else if (!byte_req) begin
			byte_ack <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// programming fsm
	////////////////////////////////////////////////////////////

	always_ff @(posedge bus or negedge arst_n) begin
		if (!arst_n) begin
			state     <= prog_idle;
			byte_cnt  <= '0;
			word_addr <= '0;
		end else begin
			case (state)
				prog_idle: begin
					// fresh start at word zero
					if (prog) begin
						state     <= prog_collect;
						byte_cnt  <= '0;
						word_addr <= '0;
					end
				end
				prog_collect: begin
					if (byte_take) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == 2'd3) begin
							state <= prog_write;
						end
					end else if (!prog) begin
						// partial word is thrown away
						state <= prog_wait_release;
					end
				end
				prog_write: begin
					// write lands this cycle
					word_addr <= word_addr + 1'b1;
					state     <= prog ? prog_collect : prog_wait_release;
				end
				prog_wait_release: begin
					byte_cnt <= '0;
					if (prog) begin
						state     <= prog_collect;
						word_addr <= '0;
					end else if (!byte_req && !byte_ack) begin
						state <= prog_idle;
					end
				end
				default: begin
					state <= prog_idle;
				end
			endcase
		end
	end

	// little endian, first byte ends up in [7:0]
	always_ff @(posedge bus) begin
		if (state == prog_collect && byte_take) begin
			word_q <= {byte_data, word_q[31:8]};
		end
	end

	assign prog_busy = (state != prog_idle);
	assign wr_en     = (state == prog_write);
	assign wr_addr   = word_addr;
	assign wr_data   = word_q;

	// memory is only written while fetch is held off
	a_wr_busy: assert property (@(posedge bus) disable iff (!arst_n)
		wr_en |-> prog_busy);

endmodule

`default_nettype wire

// ==== hw/instr_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_mem import fetch_pkg::*; #(
	parameter int IMEM_AW = 8
) (
	input  logic               bus,
	input  logic               rd_en,
	input  logic [IMEM_AW-1:0] rd_addr,
	input  logic               wr_en,
	input  logic [IMEM_AW-1:0] wr_addr,
	input  word_t              wr_data,
	output word_t              rd_data
);

	localparam int DEPTH = 2 ** IMEM_AW;

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	// one word per entry, word addressed
	word_t mem [DEPTH];

	// write port, programmer side
	always_ff @(posedge bus) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read port, fetch side
	// data shows one cycle after rd_en
	// same address collision returns the old word
	always_ff @(posedge bus) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx import fetch_pkg::*; #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic       bus,
	input  logic       arst_n,
	input  logic       rx,
	input  logic       byte_ack,
	output logic       byte_req,
	output logic [7:0] byte_data
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT) + 1;

	rx_state_e        state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_q;
	logic             mid_tick;
	logic             bit_tick;

	////////////////////////////////////////////////////////////
	// input synchronizer
	////////////////////////////////////////////////////////////

	// line idles high, so reset to one
	always_ff @(posedge bus or negedge arst_n) begin
		if (!arst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// half a bit into the start bit
	assign mid_tick = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
	// one full bit later, middle of the next bit
	assign bit_tick = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	////////////////////////////////////////////////////////////
	// receive fsm
	////////////////////////////////////////////////////////////

	always_ff @(posedge bus or negedge arst_n) begin
		if (!arst_n) begin
			state    <= rx_idle;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			byte_req <= 1'b0;
		end else begin
			case (state)
				rx_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					// falling edge of start bit
					if (!rx_sync) begin
						state <= rx_start;
					end
				end
				rx_start: begin
					if (mid_tick) begin
						clk_cnt <= '0;
						// glitch if line is back high
						state   <= rx_sync ? rx_idle : rx_data;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_data: begin
					if (bit_tick) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= rx_stop;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_stop: begin
					if (bit_tick) begin
						clk_cnt <= '0;
						// bad stop bit drops the byte
						if (rx_sync) begin
							state    <= rx_handoff;
							byte_req <= 1'b1;
						end else begin
							state <= rx_idle;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_handoff: begin
					// four phase: drop req on ack, leave once ack is low
					if (byte_ack) begin
						byte_req <= 1'b0;
					end
					if (!byte_req && !byte_ack) begin
						state <= rx_idle;
					end
				end
				default: begin
					state <= rx_idle;
				end
			endcase
		end
	end

	// lsb first, shifts in from the top
	always_ff @(posedge bus) begin
		if (state == rx_data && bit_tick) begin
			shift_q <= {rx_sync, shift_q[7:1]};
		end
	end

	// only moves in rx_data, so it holds through the handshake
	assign byte_data = shift_q;

	// payload must not move under an open request
	a_data_stable: assert property (@(posedge bus) disable iff (!arst_n)
		byte_req |=> $stable(byte_data));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the fetch testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module fetch_tb -f sources.f \
	&& ./obj_dir/Vfetch_tb > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -qx '\*\* PASS \*\*' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== sources.f ====
hw/fetch_pkg.sv
hw/uart_rx.sv
hw/imem_programmer.sv
hw/instr_mem.sv
hw/fetch_stage.sv
hw/fetch_top.sv
verification/fetch_tb.sv

// ==== verification/fetch_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_tb import fetch_pkg::*;;

	localparam int CLKS_PER_BIT = 8;
	localparam int IMEM_AW      = 8;
	localparam int TIMEOUT      = 400;
	localparam int SEED         = 64592;

	logic  bus;
	logic  arst_n;
	logic  rx;
	logic  prog;
	logic  pc_en;
	logic  branch;
	logic  jal;
	logic  jalr;
	word_t branch_off;
	word_t instr;
	word_t instr_pc;
	logic  instr_valid;
	logic  prog_busy;

	// model state, mirrors the fetch pipeline
	word_t tb_mem [2**IMEM_AW];
	word_t m_pc;
	word_t m_ipc;
	word_t m_next;
	logic  m_valid;
	logic  m_redir;
	logic  prog_d;
	int    chk_cnt;
	int    err_cnt;

	fetch_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.IMEM_AW(IMEM_AW)
	) u_fetch_top (
		.bus         (bus),
		.arst_n      (arst_n),
		.rx          (rx),
		.prog        (prog),
		.pc_en       (pc_en),
		.branch      (branch),
		.jal         (jal),
		.jalr        (jalr),
		.branch_off  (branch_off),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.instr_valid (instr_valid),
		.prog_busy   (prog_busy)
	);

	initial begin
		bus = 1'b0;
		forever #5 bus = ~bus;
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// word at a byte address, as last programmed
	function automatic word_t expected_instr(input word_t addr);
		return tb_mem[addr[IMEM_AW+1:2]];
	endfunction

	// jalr first, then branch or jal, else sequential
	function automatic word_t next_pc_model(input word_t pc, input word_t out_pc,
		input logic out_valid, input logic br, input logic j, input logic jr,
		input word_t off);
		if (out_valid && jr) begin
			return off;
		end
		if (out_valid && (br || j)) begin
			return out_pc + off;
		end
		return pc + 32'd4;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		chk_cnt++;
		assert (got === exp) else begin
			err_cnt++;
			$display("[FAIL] %s expected 0x%h got 0x%h", name, exp, got);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	task automatic abort_run(input string why);
		err_cnt++;
		$display("timeout: %s", why);
		finish_run();
	endtask

	////////////////////////////////////////////////////////////
	// compare process
	////////////////////////////////////////////////////////////

	// outputs still hold last cycle's values at the rising edge
	always @(posedge bus) begin
		if (!arst_n) begin
			m_pc    = '0;
			m_ipc   = '0;
			m_valid = 1'b0;
			prog_d  = 1'b0;
		end else begin
			check_word("instr_valid", 32'(instr_valid), 32'(m_valid));
			if (m_valid) begin
				check_word("instr_pc", instr_pc, m_ipc);
				check_word("instr", instr, expected_instr(m_ipc));
			end else begin
				check_word("instr", instr, NOP_INSTR);
			end
			// busy one cycle after prog seen high
			if (prog_d) begin
				check_word("prog_busy", 32'(prog_busy), 32'd1);
			end
			m_redir = m_valid && (branch || jal || jalr);
			m_next  = next_pc_model(m_pc, m_ipc, m_valid, branch, jal, jalr, branch_off);
			if (pc_en) begin
				m_ipc = m_pc;
			end
			if (prog) begin
				m_pc = '0;
			end else if (pc_en || m_redir) begin
				m_pc = m_next;
			end
			m_valid = pc_en;
			prog_d  = prog;
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	// start, eight data bits lsb first, stop, two idle bits
	task automatic send_byte(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int b = 0; b < 10; b++) begin
			rx = frame[b];
			repeat (CLKS_PER_BIT) @(negedge bus);
		end
		rx = 1'b1;
		repeat (2 * CLKS_PER_BIT) @(negedge bus);
	endtask

	task automatic wait_busy_low();
		int n;
		n = 0;
		while (prog_busy && n < TIMEOUT) begin
			@(negedge bus);
			n++;
		end
		if (prog_busy) begin
			abort_run("prog_busy stayed high after prog fell");
		end
	endtask

	// random words, little endian over the serial line
	task automatic load_program(input int n);
		word_t w;
		prog = 1'b1;
		for (int i = 0; i < n; i++) begin
			w = $urandom();
			tb_mem[i] = w;
			for (int b = 0; b < 4; b++) begin
				send_byte(w[8*b +: 8]);
			end
		end
		prog = 1'b0;
		wait_busy_low();
	endtask

	task automatic wait_valid_at(input word_t addr);
		int n;
		n = 0;
		while (!(instr_valid && instr_pc == addr) && n < TIMEOUT) begin
			@(negedge bus);
			n++;
		end
		if (!(instr_valid && instr_pc == addr)) begin
			abort_run("no valid instruction at the awaited address");
		end
	endtask

	task automatic wait_next_valid();
		int n;
		n = 0;
		@(negedge bus);
		while (!instr_valid && n < TIMEOUT) begin
			@(negedge bus);
			n++;
		end
		if (!instr_valid) begin
			abort_run("fetch produced no valid instruction");
		end
	endtask

	// decode role: redirect for one cycle on a valid output
	task automatic redirect_at(input word_t at, input logic br, input logic j,
		input logic jr, input word_t off);
		word_t target;
		wait_valid_at(at);
		target     = next_pc_model(at + 32'd4, at, 1'b1, br, j, jr, off);
		branch     = br;
		jal        = j;
		jalr       = jr;
		branch_off = off;
		@(negedge bus);
		// read already in flight, decode drops it
		branch     = 1'b0;
		jal        = 1'b0;
		jalr       = 1'b0;
		branch_off = '0;
		wait_next_valid();
		check_word("instr_pc", instr_pc, target);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(SEED));
		arst_n     = 1'b0;
		rx         = 1'b1;
		prog       = 1'b0;
		pc_en      = 1'b0;
		branch     = 1'b0;
		jal        = 1'b0;
		jalr       = 1'b0;
		branch_off = '0;
		chk_cnt    = 0;
		err_cnt    = 0;
		repeat (3) @(negedge bus);
		arst_n = 1'b1;
		@(negedge bus);

		// idle after reset
		check_word("instr_valid", 32'(instr_valid), 32'd0);
		check_word("prog_busy", 32'(prog_busy), 32'd0);
		check_word("instr", instr, NOP_INSTR);

		// first program, sequential run from zero
		load_program(16);
		pc_en = 1'b1;
		wait_next_valid();
		check_word("instr_pc", instr_pc, 32'd0);

		// branch and jal, both directions
		redirect_at(32'd56, 1'b1, 1'b0, 1'b0, -32'd48);
		redirect_at(32'd8, 1'b1, 1'b0, 1'b0, 32'd20);
		redirect_at(32'd28, 1'b0, 1'b1, 1'b0, -32'd16);
		redirect_at(32'd12, 1'b0, 1'b1, 1'b0, 32'd32);

		// jalr, second one also has branch set
		redirect_at(32'd44, 1'b0, 1'b0, 1'b1, 32'd16);
		redirect_at(32'd16, 1'b1, 1'b0, 1'b1, 32'd40);

		// stall, then resume at held pc
		pc_en = 1'b0;
		repeat (5) begin
			@(negedge bus);
			check_word("instr_valid", 32'(instr_valid), 32'd0);
			check_word("instr", instr, NOP_INSTR);
		end
		pc_en = 1'b1;
		wait_next_valid();
		check_word("instr_pc", instr_pc, 32'd44);
		wait_valid_at(32'd52);
		pc_en = 1'b0;

		// new contents, restart from zero
		load_program(16);
		pc_en = 1'b1;
		wait_next_valid();
		check_word("instr_pc", instr_pc, 32'd0);
		wait_valid_at(32'd60);
		pc_en = 1'b0;
		repeat (4) @(negedge bus);
		finish_run();
	end

endmodule

`default_nettype wire
